// ==== source/fpnc_pkg.sv ====
`default_nettype none

package fpnc_pkg;

  // ------------------------------
  // Widths and sizes
  // ------------------------------
  localparam int unsigned WIDTH         = 32;
  localparam int unsigned TAG_WIDTH     = 4;
  localparam int unsigned NUM_OPERANDS  = 2;
  localparam int unsigned NUM_FORMATS   = 2;
  localparam int unsigned FMT_BITS      = $clog2(NUM_FORMATS);
  localparam int unsigned NUM_PIPE_REGS = 2;

  // Field widths per format
  localparam int unsigned EXP_BITS_FP32 = 8;
  localparam int unsigned MAN_BITS_FP32 = 23;
  localparam int unsigned EXP_BITS_FP16 = 5;
  localparam int unsigned MAN_BITS_FP16 = 10;

  // Quiet NaN with only the top mantissa bit set
  localparam logic [31:0] CANON_NAN_FP32 = 32'h7fc0_0000;
  localparam logic [15:0] CANON_NAN_FP16 = 16'h7e00;

  // ------------------------------
  // Enumerations
  // ------------------------------
  typedef enum logic [0:0] {
    FP32 = 1'b0,
    FP16 = 1'b1
  } fp_format_e;

  typedef enum logic [1:0] {
    SGNJ   = 2'd0,
    MINMAX = 2'd1,
    CMP    = 2'd2
  } operation_e;

  // Rounding mode field doubles as the operation variant
  typedef enum logic [2:0] {
    RNE = 3'b000,
    RTZ = 3'b001,
    RDN = 3'b010,
    RUP = 3'b011,
    RMM = 3'b100,
    DYN = 3'b111
  } roundmode_e;

  typedef struct packed {
    logic NV;
    logic DZ;
    logic OF;
    logic UF;
    logic NX;
  } status_t;

  // ------------------------------
  // Format helpers
  // ------------------------------
  function automatic int unsigned exp_bits(fp_format_e fmt);
    return (fmt == FP32) ? EXP_BITS_FP32 : EXP_BITS_FP16;
  endfunction

  function automatic int unsigned man_bits(fp_format_e fmt);
    return (fmt == FP32) ? MAN_BITS_FP32 : MAN_BITS_FP16;
  endfunction

  function automatic int unsigned fp_width(fp_format_e fmt);
    return 1 + exp_bits(fmt) + man_bits(fmt);
  endfunction

  // Canonical NaN right-aligned in an operand word
  function automatic logic [WIDTH-1:0] canon_nan(fp_format_e fmt);
    return (fmt == FP32) ? CANON_NAN_FP32 : {16'h0000, CANON_NAN_FP16};
  endfunction

endpackage

`default_nettype wire

// ==== source/fpnc_result_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// Result channel from one format slice to the arbiter
interface fpnc_result_if import fpnc_pkg::*; ();

  logic                 valid;
  logic                 ready;
  logic [WIDTH-1:0]     result;
  status_t              status;
  logic [TAG_WIDTH-1:0] tag;

  modport slice (
    output valid,
    output result,
    output status,
    output tag,
    input  ready
  );

  modport arb (
    input  valid,
    input  result,
    input  status,
    input  tag,
    output ready
  );

endinterface

`default_nettype wire

// ==== source/fpnc_fmt_slice.sv ====
`timescale 1ns/1ps
`default_nettype none

module fpnc_fmt_slice import fpnc_pkg::*; #(
  parameter fp_format_e FpFormat = FP32
) (
  input  logic                                 clk_i,
  input  logic                                 arst_n_i,
  input  logic [NUM_OPERANDS-1:0][WIDTH-1:0]   operands_i,
  input  operation_e                           op_i,
  input  roundmode_e                           rnd_mode_i,
  input  logic [TAG_WIDTH-1:0]                 tag_i,
  input  logic                                 in_valid_i,
  output logic                                 in_ready_o,
  input  logic                                 flush_i,
  output logic                                 busy_o,
  fpnc_result_if.slice                         res
);

  localparam int unsigned FP_WIDTH = fp_width(FpFormat);
  localparam int unsigned EXP_BITS = exp_bits(FpFormat);
  localparam int unsigned MAN_BITS = man_bits(FpFormat);
  localparam logic [WIDTH-1:0] CANON_NAN = canon_nan(FpFormat);

  // ------------------------------
  // Operand classification
  // ------------------------------
  logic [FP_WIDTH-1:0] op_a, op_b;
  logic                sign_a, sign_b;
  logic [EXP_BITS-1:0] exp_a, exp_b;
  logic [MAN_BITS-1:0] man_a, man_b;
  logic                nan_a, nan_b, snan_a, snan_b, zero_a, zero_b;
  logic                ops_equal, a_smaller;

  assign op_a = operands_i[0][FP_WIDTH-1:0];
  assign op_b = operands_i[1][FP_WIDTH-1:0];
  assign {sign_a, exp_a, man_a} = op_a;
  assign {sign_b, exp_b, man_b} = op_b;

  assign nan_a  = (&exp_a) & (|man_a);
  assign nan_b  = (&exp_b) & (|man_b);
  assign snan_a = nan_a & ~man_a[MAN_BITS-1];
  assign snan_b = nan_b & ~man_b[MAN_BITS-1];
  assign zero_a = ~(|{exp_a, man_a});
  assign zero_b = ~(|{exp_b, man_b});

  // Bit-pattern compare, inverted when a negative value is involved
  assign ops_equal = (op_a == op_b) | (zero_a & zero_b);
  assign a_smaller = (op_a < op_b) ^ (sign_a | sign_b);

  // ------------------------------
  // Stage one compute
  // ------------------------------
  logic [FP_WIDTH-1:0] fp_res;
  logic                cmp_res, is_cmp, nv;

  always_comb begin
    fp_res  = op_a;
    cmp_res = 1'b0;
    is_cmp  = 1'b0;
    nv      = 1'b0;
    case (op_i)
      SGNJ: begin
        case (rnd_mode_i)
          RNE:     fp_res = {sign_b, op_a[FP_WIDTH-2:0]};
          RTZ:     fp_res = {~sign_b, op_a[FP_WIDTH-2:0]};
          RDN:     fp_res = {sign_a ^ sign_b, op_a[FP_WIDTH-2:0]};
          default: fp_res = op_a;
        endcase
      end
      MINMAX: begin
        nv = snan_a | snan_b;
        if (nan_a && nan_b) begin
          fp_res = CANON_NAN[FP_WIDTH-1:0];
        end else if (nan_a) begin
          fp_res = op_b;
        end else if (nan_b) begin
          fp_res = op_a;
        end else begin
          case (rnd_mode_i)
            RNE:     fp_res = a_smaller ? op_a : op_b;
            RTZ:     fp_res = a_smaller ? op_b : op_a;
            default: fp_res = CANON_NAN[FP_WIDTH-1:0];
          endcase
        end
      end
      CMP: begin
        is_cmp = 1'b1;
        case (rnd_mode_i)
          RNE: begin
            nv      = nan_a | nan_b;
            cmp_res = ~(nan_a | nan_b) & (a_smaller | ops_equal);
          end
          RTZ: begin
            nv      = nan_a | nan_b;
            cmp_res = ~(nan_a | nan_b) & a_smaller & ~ops_equal;
          end
          RDN: begin
            nv      = snan_a | snan_b;
            cmp_res = ~(nan_a | nan_b) & ops_equal;
          end
          default: cmp_res = 1'b0;
        endcase
      end
      default: fp_res = op_a;
    endcase
  end

  // ------------------------------
  // Pipeline stages
  // ------------------------------
  // Index 0 is the incoming operation, 1..N are registers
  logic    [0:NUM_PIPE_REGS]                stage_valid;
  logic    [0:NUM_PIPE_REGS]                stage_ready;
  logic    [0:NUM_PIPE_REGS][WIDTH-1:0]     stage_result;
  status_t [0:NUM_PIPE_REGS]                stage_status;
  logic    [0:NUM_PIPE_REGS][TAG_WIDTH-1:0] stage_tag;

  always_comb begin
    // FP16 payload gets NaN-boxed, compare results are plain 0/1
    stage_result[0] = '1;
    if (is_cmp) begin
      stage_result[0] = {{(WIDTH-1){1'b0}}, cmp_res};
    end else begin
      stage_result[0][FP_WIDTH-1:0] = fp_res;
    end
  end

  assign stage_valid[0]  = in_valid_i;
  assign stage_status[0] = '{NV: nv, default: 1'b0};
  assign stage_tag[0]    = tag_i;

  assign stage_ready[NUM_PIPE_REGS] = res.ready;

  for (genvar k = 0; k < int'(NUM_PIPE_REGS); k++) begin : gen_stages
    // Stage k+1 takes data when empty or draining
    assign stage_ready[k] = ~stage_valid[k+1] | stage_ready[k+1];

    always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
        stage_valid[k+1] <= 1'b0;
      end else if (flush_i) begin
        stage_valid[k+1] <= 1'b0;
      end else if (stage_ready[k]) begin
        stage_valid[k+1] <= stage_valid[k];
      end
    end

    always_ff @(posedge clk_i) begin
      if (stage_ready[k] && stage_valid[k]) begin
        stage_result[k+1] <= stage_result[k];
        stage_status[k+1] <= stage_status[k];
        stage_tag[k+1]    <= stage_tag[k];
      end
    end
  end

  assign in_ready_o = stage_ready[0];
  assign busy_o     = |stage_valid[1:NUM_PIPE_REGS];

  assign res.valid  = stage_valid[NUM_PIPE_REGS];
  assign res.result = stage_result[NUM_PIPE_REGS];
  assign res.status = stage_status[NUM_PIPE_REGS];
  assign res.tag    = stage_tag[NUM_PIPE_REGS];

  // ------------------------------
  // Assertions
  // ------------------------------
  a_payload_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    res.valid && !res.ready |=>
      $stable(res.result) && $stable(res.status) && $stable(res.tag));

  // Every stage empties on a flush
  a_flush_clears: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    flush_i |=> !busy_o);

endmodule

`default_nettype wire

// ==== source/fpnc_rr_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module fpnc_rr_arbiter import fpnc_pkg::*; (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  logic                 flush_i,
  fpnc_result_if.arb           req [NUM_FORMATS],
  input  logic                 out_ready_i,
  output logic                 out_valid_o,
  output logic [WIDTH-1:0]     result_o,
  output status_t              status_o,
  output logic [TAG_WIDTH-1:0] tag_o
);

  logic    [NUM_FORMATS-1:0]                req_valid;
  logic    [NUM_FORMATS-1:0]                req_ready;
  logic    [NUM_FORMATS-1:0][WIDTH-1:0]     req_result;
  status_t [NUM_FORMATS-1:0]                req_status;
  logic    [NUM_FORMATS-1:0][TAG_WIDTH-1:0] req_tag;

  logic [FMT_BITS-1:0] rr_ptr_q, lock_idx_q, gnt_idx;
  logic                lock_q;

  // Gather the request channels
  for (genvar i = 0; i < int'(NUM_FORMATS); i++) begin : gen_req
    assign req_valid[i]  = req[i].valid;
    assign req_result[i] = req[i].result;
    assign req_status[i] = req[i].status;
    assign req_tag[i]    = req[i].tag;
    assign req_ready[i]  = out_ready_i & (gnt_idx == FMT_BITS'(i));
    assign req[i].ready  = req_ready[i];
  end

  // ------------------------------
  // Grant selection
  // ------------------------------
  always_comb begin
    gnt_idx = rr_ptr_q;
    if (lock_q) begin
      gnt_idx = lock_idx_q;
    end else begin
      // Walk backwards so the request closest to the pointer wins
      for (int k = NUM_FORMATS - 1; k >= 0; k--) begin
        if (req_valid[(int'(rr_ptr_q) + k) % NUM_FORMATS]) begin
          gnt_idx = FMT_BITS'((int'(rr_ptr_q) + k) % NUM_FORMATS);
        end
      end
    end
  end

  assign out_valid_o = req_valid[gnt_idx];
  assign result_o    = req_result[gnt_idx];
  assign status_o    = req_status[gnt_idx];
  assign tag_o       = req_tag[gnt_idx];

  // Hold the grant across a stall, advance after a transfer
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rr_ptr_q   <= '0;
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
    end else if (flush_i) begin
      lock_q <= 1'b0;
    end else begin
      lock_q     <= out_valid_o & ~out_ready_i;
      lock_idx_q <= gnt_idx;
      if (out_valid_o && out_ready_i) begin
        rr_ptr_q <= (gnt_idx == FMT_BITS'(NUM_FORMATS - 1)) ? '0 : gnt_idx + 1'b1;
      end
    end
  end

  // The other waiting slice is served right after a transfer
  a_rr_alternate: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    out_valid_o && out_ready_i && (&req_valid) && !flush_i |=>
      gnt_idx != $past(gnt_idx));

  a_grant_held: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    out_valid_o && !out_ready_i && !flush_i |=> gnt_idx == $past(gnt_idx));

endmodule

`default_nettype wire

// ==== source/fpnc_opgroup_block.sv ====
`timescale 1ns/1ps
`default_nettype none

module fpnc_opgroup_block import fpnc_pkg::*; (
  input  logic                               clk_i,
  input  logic                               arst_n_i,
  // Operation in
  input  logic [NUM_OPERANDS-1:0][WIDTH-1:0] operands_i,
  input  operation_e                         op_i,
  input  roundmode_e                         rnd_mode_i,
  input  fp_format_e                         dst_fmt_i,
  input  logic [TAG_WIDTH-1:0]               tag_i,
  input  logic                               in_valid_i,
  output logic                               in_ready_o,
  input  logic                               flush_i,
  // Result out
  output logic [WIDTH-1:0]                   result_o,
  output status_t                            status_o,
  output logic [TAG_WIDTH-1:0]               tag_o,
  output logic                               out_valid_o,
  input  logic                               out_ready_i,
  output logic                               busy_o
);

  logic [NUM_FORMATS-1:0] slice_in_valid;
  logic [NUM_FORMATS-1:0] slice_in_ready;
  logic [NUM_FORMATS-1:0] slice_busy;

  fpnc_result_if res_if [NUM_FORMATS] ();

  // ------------------------------
  // Dispatch
  // ------------------------------
  // Only the slice of the destination format sees the request
  assign in_ready_o = slice_in_ready[dst_fmt_i];

  for (genvar fmt = 0; fmt < int'(NUM_FORMATS); fmt++) begin : gen_slices
    assign slice_in_valid[fmt] = in_valid_i & (dst_fmt_i == fp_format_e'(fmt));

    fpnc_fmt_slice #(
      .FpFormat ( fp_format_e'(fmt) )
    ) i_fmt_slice (
      .clk_i,
      .arst_n_i,
      .operands_i,
      .op_i,
      .rnd_mode_i,
      .tag_i,
      .in_valid_i ( slice_in_valid[fmt] ),
      .in_ready_o ( slice_in_ready[fmt] ),
      .flush_i,
      .busy_o     ( slice_busy[fmt]     ),
      .res        ( res_if[fmt]         )
    );
  end

  // ------------------------------
  // Result merge
  // ------------------------------
  fpnc_rr_arbiter i_arbiter (
    .clk_i,
    .arst_n_i,
    .flush_i,
    .req         ( res_if      ),
    .out_ready_i,
    .out_valid_o,
    .result_o,
    .status_o,
    .tag_o
  );

  // Anything in flight in either slice
  assign busy_o = |slice_busy;

endmodule

`default_nettype wire

// ==== sim/fpnc_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module fpnc_checker import fpnc_pkg::*; (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  logic                 in_valid_i,
  input  logic                 in_ready_i,
  input  logic [TAG_WIDTH-1:0] in_tag_i,
  input  logic [WIDTH-1:0]     exp_result_i,
  input  status_t              exp_status_i,
  input  logic                 flush_i,
  input  logic                 out_valid_i,
  input  logic                 out_ready_i,
  input  logic [WIDTH-1:0]     result_i,
  input  status_t              status_i,
  input  logic [TAG_WIDTH-1:0] out_tag_i,
  input  logic                 busy_i,
  output int unsigned          mismatch_count_o,
  output int unsigned          protocol_count_o,
  output int unsigned          outstanding_o
);

  localparam int unsigned NUM_TAGS = 2 ** TAG_WIDTH;

  // Expected response per tag
  logic [WIDTH-1:0]     exp_result [NUM_TAGS];
  status_t              exp_status [NUM_TAGS];
  logic [NUM_TAGS-1:0]  pending;

  logic                 seen_input;
  logic                 was_stalled;
  logic                 was_flushed;
  logic [WIDTH-1:0]     held_result;
  status_t              held_status;
  logic [TAG_WIDTH-1:0] held_tag;

  initial begin
    mismatch_count_o = 0;
    protocol_count_o = 0;
    pending          = '0;
    seen_input       = 1'b0;
    was_stalled      = 1'b0;
    was_flushed      = 1'b0;
  end

  assign outstanding_o = $countones(pending);

  task automatic compare_field(input string name, input logic [WIDTH-1:0] expected,
                               input logic [WIDTH-1:0] actual);
    if (actual !== expected) begin
      $display("MISMATCH t=%0t %s expected=%h actual=%h", $time, name, expected, actual);
      mismatch_count_o++;
    end
  endtask

  task automatic check_output();
    if (!pending[out_tag_i]) begin
      $display("At %0t a result came back with tag %0d, which is not in flight",
               $time, out_tag_i);
      protocol_count_o++;
    end else begin
      compare_field("result_o", exp_result[out_tag_i], result_i);
      compare_field("status_o", WIDTH'(exp_status[out_tag_i]), WIDTH'(status_i));
      pending[out_tag_i] = 1'b0;
    end
  endtask

  task automatic record_input();
    if (pending[in_tag_i]) begin
      $display("At %0t tag %0d was accepted again while still in flight", $time, in_tag_i);
      protocol_count_o++;
    end
    pending[in_tag_i]    = 1'b1;
    exp_result[in_tag_i] = exp_result_i;
    exp_status[in_tag_i] = exp_status_i;
    seen_input           = 1'b1;
  endtask

  // ------------------------------
  // Per-edge checks
  // ------------------------------
  always @(posedge clk_i) begin
    if (arst_n_i) begin
      if (!seen_input && (out_valid_i || busy_i)) begin
        $display("At %0t out_valid_o or busy_o is high before any operation", $time);
        protocol_count_o++;
      end
      if (was_flushed && busy_i) begin
        $display("At %0t busy_o is still high on the cycle after a flush", $time);
        protocol_count_o++;
      end
      // Stalled payload must hold
      if (was_stalled && !out_valid_i) begin
        $display("At %0t out_valid_o dropped before its result was taken", $time);
        protocol_count_o++;
      end else if (was_stalled) begin
        compare_field("result_o", held_result, result_i);
        compare_field("status_o", WIDTH'(held_status), WIDTH'(status_i));
        compare_field("tag_o", WIDTH'(held_tag), WIDTH'(out_tag_i));
      end
      if (out_valid_i && out_ready_i) begin
        check_output();
      end
      if (in_valid_i && in_ready_i) begin
        record_input();
      end
      // Flushed operations never come back
      if (flush_i) begin
        pending = '0;
      end
      was_stalled = out_valid_i && !out_ready_i && !flush_i;
      was_flushed = flush_i;
      held_result = result_i;
      held_status = status_i;
      held_tag    = out_tag_i;
    end
  end

endmodule

`default_nettype wire

// ==== sim/tb_fpnc_opgroup_block.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_fpnc_opgroup_block import fpnc_pkg::*; ();

  localparam int unsigned COLS     = 9;
  localparam int unsigned MAX_VECS = 64;
  localparam logic [31:0] EMPTY    = 32'hffff_ffff;
  localparam logic [31:0] SEED     = 32'ha2d6_b3a0;

  logic                               clk;
  logic                               arst_n;
  logic [NUM_OPERANDS-1:0][WIDTH-1:0] operands;
  operation_e                         op;
  roundmode_e                         rnd_mode;
  fp_format_e                         dst_fmt;
  logic [TAG_WIDTH-1:0]               tag;
  logic                               in_valid, in_ready, flush;
  logic [WIDTH-1:0]                   result;
  status_t                            status;
  logic [TAG_WIDTH-1:0]               out_tag;
  logic                               out_valid, out_ready, busy;

  // Expected values travel next to the operation into the checker
  logic [WIDTH-1:0]                   exp_result;
  status_t                            exp_status;
  int unsigned                        mismatch_count, protocol_count, outstanding;

  logic [31:0]                        vec_mem [MAX_VECS*COLS];
  int unsigned                        num_vecs = 0;
  logic [31:0]                        rnd_state = SEED;

  fpnc_opgroup_block i_dut (
    .clk_i       ( clk        ),
    .arst_n_i    ( arst_n     ),
    .operands_i  ( operands   ),
    .op_i        ( op         ),
    .rnd_mode_i  ( rnd_mode   ),
    .dst_fmt_i   ( dst_fmt    ),
    .tag_i       ( tag        ),
    .in_valid_i  ( in_valid   ),
    .in_ready_o  ( in_ready   ),
    .flush_i     ( flush      ),
    .result_o    ( result     ),
    .status_o    ( status     ),
    .tag_o       ( out_tag    ),
    .out_valid_o ( out_valid  ),
    .out_ready_i ( out_ready  ),
    .busy_o      ( busy       )
  );

  fpnc_checker i_checker (
    .clk_i            ( clk            ),
    .arst_n_i         ( arst_n         ),
    .in_valid_i       ( in_valid       ),
    .in_ready_i       ( in_ready       ),
    .in_tag_i         ( tag            ),
    .exp_result_i     ( exp_result     ),
    .exp_status_i     ( exp_status     ),
    .flush_i          ( flush          ),
    .out_valid_i      ( out_valid      ),
    .out_ready_i      ( out_ready      ),
    .result_i         ( result         ),
    .status_i         ( status         ),
    .out_tag_i        ( out_tag        ),
    .busy_i           ( busy           ),
    .mismatch_count_o ( mismatch_count ),
    .protocol_count_o ( protocol_count ),
    .outstanding_o    ( outstanding    )
  );

  // ------------------------------
  // Clock and back-pressure
  // ------------------------------
  always #4 clk = ~clk;

  function automatic logic [31:0] next_random(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Ready about three cycles in four
  always @(posedge clk) begin
    #1;
    rnd_state = next_random(rnd_state);
    out_ready = (rnd_state[1:0] != 2'b00);
  end

  // ------------------------------
  // Stimulus
  // ------------------------------
  task automatic load_vectors();
    for (int unsigned w = 0; w < MAX_VECS * COLS; w++) begin
      vec_mem[w] = EMPTY;
    end
    $readmemh("sim/fpnc_testdata.hex", vec_mem);
    while (num_vecs < MAX_VECS && vec_mem[num_vecs * COLS] != EMPTY) begin
      num_vecs++;
    end
    if (num_vecs == 0) begin
      $display("No vectors could be read from sim/fpnc_testdata.hex");
    end
  endtask

  // Holds the operation until the targeted slice takes it
  task automatic apply_op(input int unsigned v);
    int unsigned base;
    base = v * COLS;
    #1;
    dst_fmt     = fp_format_e'(vec_mem[base + 1][0]);
    op          = operation_e'(vec_mem[base + 2][1:0]);
    rnd_mode    = roundmode_e'(vec_mem[base + 3][2:0]);
    operands[0] = vec_mem[base + 4];
    operands[1] = vec_mem[base + 5];
    tag         = vec_mem[base + 6][TAG_WIDTH-1:0];
    exp_result  = vec_mem[base + 7];
    exp_status  = status_t'(vec_mem[base + 8][4:0]);
    in_valid    = 1'b1;
    @(posedge clk);
    while (!in_ready) begin
      @(posedge clk);
    end
  endtask

  task automatic apply_flush();
    #1;
    in_valid = 1'b0;
    flush    = 1'b1;
    @(posedge clk);
    #1;
    flush = 1'b0;
    @(posedge clk);
  endtask

  task automatic print_summary();
    $display("Errors: %0d mismatches, %0d protocol errors, %0d operations never returned",
             mismatch_count, protocol_count, outstanding);
  endtask

  initial begin
    clk        = 1'b0;
    arst_n     = 1'b0;
    operands   = '0;
    op         = SGNJ;
    rnd_mode   = RNE;
    dst_fmt    = FP32;
    tag        = '0;
    in_valid   = 1'b0;
    flush      = 1'b0;
    out_ready  = 1'b0;
    exp_result = '0;
    exp_status = '0;
    load_vectors();
    repeat (10) @(posedge clk);
    #1 arst_n = 1'b1;
    repeat (3) @(posedge clk);
    for (int unsigned v = 0; v < num_vecs; v++) begin
      if (vec_mem[v * COLS][0]) begin
        apply_flush();
      end else begin
        apply_op(v);
      end
    end
    #1 in_valid = 1'b0;
    // Drain whatever is still in the slices
    while (outstanding != 0) begin
      @(posedge clk);
      #1;
    end
    repeat (4) @(posedge clk);
    #1;
    print_summary();
    if (mismatch_count == 0 && protocol_count == 0 && num_vecs != 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  // Watchdog sized from the vector count
  initial begin
    wait (num_vecs != 0);
    repeat (num_vecs * 40 + 200) @(posedge clk);
    #1;
    $display("Watchdog expired with %0d operations still outstanding", outstanding);
    print_summary();
    $display(">>> FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim/fpnc_testdata.hex ====
// flush fmt op variant operand_a operand_b tag expected_result expected_status
// fmt 0=FP32 1=FP16, op 0=SGNJ 1=MINMAX 2=CMP, variant 0=RNE 1=RTZ 2=RDN, status 10=NV
0 0 0 0 3f800000 c0000000 0 bf800000 00
0 1 0 0 ffff3c00 ffffc000 1 ffffbc00 00
0 0 0 1 3f800000 c0000000 2 3f800000 00
0 1 0 1 ffffbc00 ffff4000 3 ffffbc00 00
0 0 0 2 bf800000 c0000000 4 3f800000 00
0 1 0 2 ffff4000 ffffc000 5 ffffc000 00
0 0 0 1 7f800001 3f800000 6 ff800001 00
0 0 1 0 3f800000 c0000000 7 c0000000 00
0 1 1 1 ffff3c00 ffff4000 8 ffff4000 00
0 0 1 0 00000000 80000000 9 80000000 00
0 1 1 1 ffff8000 ffff0000 a ffff0000 00
0 0 1 1 7fc00000 40000000 b 40000000 00
0 1 1 0 ffff3c00 ffff7e00 c ffff3c00 00
0 0 1 0 ffc00123 7fc00000 d 7fc00000 00
0 1 1 1 ffff7c01 ffff7e00 e ffff7e00 10
0 0 1 0 7f800001 3f800000 f 3f800000 10
0 1 1 1 ffffc000 ffff7c01 0 ffffc000 10
0 0 1 1 c0000000 bf800000 1 bf800000 00
0 0 0 0 40400000 80000000 2 c0400000 00
0 1 0 2 ffffbc00 ffffbc00 3 ffff3c00 00
1 0 0 0 00000000 00000000 0 00000000 00
0 0 2 2 3f800000 3f800000 4 00000001 00
0 0 2 2 7fc00000 3f800000 5 00000000 00
0 0 2 2 7f800001 3f800000 6 00000000 10
0 1 2 1 ffffbc00 ffff3c00 7 00000001 00
0 1 2 1 ffff7e00 ffff3c00 8 00000000 10
0 0 2 0 80000000 00000000 9 00000001 00
0 0 2 1 80000000 00000000 a 00000000 00
0 1 2 0 ffff3c00 ffff7c01 b 00000000 10
0 1 2 2 ffff7c01 ffff7c01 c 00000000 10
0 1 2 2 ffff0000 ffff8000 d 00000001 00
0 0 2 0 40000000 3f800000 e 00000000 00

// ==== compile.f ====
source/fpnc_pkg.sv
source/fpnc_result_if.sv
source/fpnc_fmt_slice.sv
source/fpnc_rr_arbiter.sv
source/fpnc_opgroup_block.sv
sim/fpnc_checker.sv
sim/tb_fpnc_opgroup_block.sv

// ==== Makefile ====
# Verilator build and run of the FP non-computational block

VERILATOR ?= verilator
TOP       ?= tb_fpnc_opgroup_block
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# Rebuilt only when a listed source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q '>>> FAIL' $(LOG); then \
	  echo "Simulation reported failure, see $(LOG)"; exit 1; \
	elif ! grep -q '>>> PASS' $(LOG); then \
	  echo "Simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
